//--- src/arc_macros.svh
`ifndef ARC_MACROS_SVH
`define ARC_MACROS_SVH

// ROM map limits, CPU code starts at 0
`define ARC_SND_BASE  20'h20000
`define ARC_GFX_BASE  20'h30000
`define ARC_PROM_BASE 20'hA0000
`define ARC_ROM_END   20'hA0920

`define ARC_RST_HOLD  64 // Game reset hold in clk_sys cycles

// PS/2 set 2 scan codes
`define ARC_KEY_UP     8'h75
`define ARC_KEY_DOWN   8'h72
`define ARC_KEY_LEFT   8'h6b
`define ARC_KEY_RIGHT  8'h74
`define ARC_KEY_FIRE_A 8'h14
`define ARC_KEY_FIRE_B 8'h11
`define ARC_KEY_COIN   8'h2e
`define ARC_KEY_START  8'h16

`endif

//--- src/arc_pkg.sv
package arc_pkg;

	// Shell sequencing
	typedef enum logic [1:0] {
		ST_BOOT = 2'd0,
		ST_LOAD = 2'd1,
		ST_HOLD = 2'd2,
		ST_RUN  = 2'd3
	} shell_state_t;

	// Download address classes, see ROM map in arc_macros.svh
	typedef enum logic [2:0] {
		RGN_CPU  = 3'd0,
		RGN_SND  = 3'd1,
		RGN_GFX  = 3'd2,
		RGN_PROM = 3'd3,
		RGN_NONE = 3'd4
	} rom_region_t;

	// Board variants as reported by the host core_mod field
	typedef enum logic [6:0] {
		HW_LDRUN    = 7'd0,
		HW_LDRUN4   = 7'd3,
		HW_BATTROAD = 7'd6,
		HW_YOUJYUDN = 7'd11
	} hw_variant_t;

endpackage

//--- src/arc_shell_ctrl.sv
`timescale 1ns/1ps

`include "arc_macros.svh"

module arc_shell_ctrl (
	input  logic                  clk_sys,
	input  logic                  rst_n_i,
	input  logic                  ioctl_downl_i,
	input  logic                  rst_req_i,
	output logic                  core_reset_o,
	output logic                  led_o,
	output arc_pkg::shell_state_t state_o
);

	localparam int HOLD_W = $clog2(`ARC_RST_HOLD);
	localparam logic [HOLD_W-1:0] HOLD_LAST = HOLD_W'(`ARC_RST_HOLD - 1);

	arc_pkg::shell_state_t state;
	arc_pkg::shell_state_t state_nxt;
	logic                  downl_d;
	logic                  dl_rise;
	logic                  dl_fall;
	logic                  rom_loaded;
	logic                  load_hold;
	logic [HOLD_W-1:0]     hold_cnt;

	assign dl_rise = ioctl_downl_i & ~downl_d;
	assign dl_fall = downl_d & ~ioctl_downl_i;
	assign state_o = state;

	always_comb begin
		state_nxt = state;
		load_hold = 1'b0;
		case (state)
			arc_pkg::ST_LOAD: if (dl_fall) begin
				state_nxt = arc_pkg::ST_HOLD;
				load_hold = 1'b1;
			end
			arc_pkg::ST_HOLD: begin
				if (rst_req_i)
					load_hold = 1'b1; // Hold restarts while request is up
				else if (hold_cnt == '0 && rom_loaded)
					state_nxt = arc_pkg::ST_RUN;
			end
			arc_pkg::ST_RUN: if (rst_req_i) begin
				state_nxt = arc_pkg::ST_HOLD;
				load_hold = 1'b1;
			end
			default: ; // Boot waits for the first download
		endcase
		if (dl_rise)
			state_nxt = arc_pkg::ST_LOAD;
	end

	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state        <= arc_pkg::ST_BOOT;
			downl_d      <= 1'b0;
			rom_loaded   <= 1'b0;
			hold_cnt     <= '0;
			core_reset_o <= 1'b1;
			led_o        <= 1'b0;
		end else begin
			downl_d      <= ioctl_downl_i;
			led_o        <= ~ioctl_downl_i;
			state        <= state_nxt;
			core_reset_o <= (state_nxt != arc_pkg::ST_RUN); // Tracks state, no extra lag
			if (dl_fall)
				rom_loaded <= 1'b1;
			if (load_hold)
				hold_cnt <= HOLD_LAST;
			else if (state == arc_pkg::ST_HOLD && hold_cnt != '0)
				hold_cnt <= hold_cnt - 1'b1;
		end
	end

endmodule

//--- src/arc_dl_router.sv
`timescale 1ns/1ps

`include "arc_macros.svh"

module arc_dl_router (
	input  logic                 clk_sys,
	input  logic                 rst_n_i,
	input  logic                 ioctl_downl_i,
	input  logic                 ioctl_wr_i,
	input  logic [24:0]          ioctl_addr_i,
	input  logic [7:0]           ioctl_dout_i,
	output logic                 port1_req_o,
	output logic                 port2_req_o,
	output arc_pkg::rom_region_t region_o,
	output logic                 prom_wr_o,
	output logic [11:0]          prom_addr_o,
	output logic [7:0]           prom_data_o
);

	localparam logic [24:0] SND_BASE  = 25'(`ARC_SND_BASE);
	localparam logic [24:0] GFX_BASE  = 25'(`ARC_GFX_BASE);
	localparam logic [24:0] PROM_BASE = 25'(`ARC_PROM_BASE);
	localparam logic [24:0] ROM_END   = 25'(`ARC_ROM_END);

	logic                 wr_d;
	logic                 wr_rise;
	logic [24:0]          prom_off;
	arc_pkg::rom_region_t rgn;

	assign wr_rise  = ioctl_downl_i & ioctl_wr_i & ~wr_d;
	assign prom_off = ioctl_addr_i - PROM_BASE;

	always_comb begin
		if (ioctl_addr_i < SND_BASE)
			rgn = arc_pkg::RGN_CPU;
		else if (ioctl_addr_i < GFX_BASE)
			rgn = arc_pkg::RGN_SND;
		else if (ioctl_addr_i < PROM_BASE)
			rgn = arc_pkg::RGN_GFX;
		else if (ioctl_addr_i < ROM_END)
			rgn = arc_pkg::RGN_PROM;
		else
			rgn = arc_pkg::RGN_NONE;
	end

	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_d        <= 1'b0;
			port1_req_o <= 1'b0;
			port2_req_o <= 1'b0;
			region_o    <= arc_pkg::RGN_CPU;
			prom_wr_o   <= 1'b0;
			prom_addr_o <= '0;
			prom_data_o <= '0;
		end else begin
			wr_d      <= ioctl_wr_i;
			prom_wr_o <= 1'b0;
			if (wr_rise) begin
				port1_req_o <= ~port1_req_o;
				if (ioctl_addr_i >= GFX_BASE)
					port2_req_o <= ~port2_req_o; // Sprite port sees GFX and up
				region_o <= rgn;
				if (rgn == arc_pkg::RGN_PROM) begin
					prom_wr_o   <= 1'b1;
					prom_addr_o <= prom_off[11:0];
					prom_data_o <= ioctl_dout_i;
				end
			end
		end
	end

endmodule

//--- src/arc_cfg_decode.sv
`timescale 1ns/1ps

module arc_cfg_decode (
	input  logic                 clk_sys,
	input  logic                 rst_n_i,
	input  logic [31:0]          status_i,
	input  arc_pkg::hw_variant_t core_mod_i,
	output logic                 palmode_o,
	output logic [1:0]           rotate_o,
	output logic [1:0]           scanlines_o,
	output logic                 blend_o,
	output logic                 service_o,
	output logic                 joyswap_o,
	output logic [1:0]           orientation_o,
	output logic                 oneplayer_o,
	output logic [7:0]           dsw1_o
);

	logic [1:0] orient;
	logic       one_p;

	// Per-board screen mounting and player count
	always_comb begin
		orient = 2'b10;
		one_p  = 1'b1;
		case (core_mod_i)
			arc_pkg::HW_LDRUN4:   one_p  = 1'b0;
			arc_pkg::HW_BATTROAD: orient = 2'b11;
			arc_pkg::HW_YOUJYUDN: orient = 2'b01;
			default: ;
		endcase
	end

	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			palmode_o     <= 1'b0;
			rotate_o      <= '0;
			scanlines_o   <= '0;
			blend_o       <= 1'b0;
			service_o     <= 1'b0;
			joyswap_o     <= 1'b0;
			orientation_o <= '0;
			oneplayer_o   <= 1'b0;
			dsw1_o        <= '0;
		end else begin
			palmode_o     <= status_i[1];
			rotate_o      <= {orient[1], status_i[2]};
			scanlines_o   <= status_i[4:3];
			blend_o       <= status_i[5];
			service_o     <= status_i[7];
			joyswap_o     <= status_i[6];
			orientation_o <= orient;
			oneplayer_o   <= one_p;
			dsw1_o        <= {4'hf, ~status_i[11:8]}; // Coinage fixed, DIPs active low
		end
	end

endmodule

//--- src/arc_input_map.sv
`timescale 1ns/1ps

`include "arc_macros.svh"

module arc_input_map (
	input  logic       clk_sys,
	input  logic       rst_n_i,
	input  logic       key_strobe_i,
	input  logic       key_pressed_i,
	input  logic [7:0] key_code_i,
	input  logic [7:0] joy0_i,
	input  logic [7:0] joy1_i,
	input  logic       rotate_i,
	input  logic [1:0] orientation_i,
	input  logic       joyswap_i,
	input  logic       oneplayer_i,
	output logic [3:0] p1_dir_o,
	output logic [1:0] p1_btn_o,
	output logic [3:0] p2_dir_o,
	output logic [1:0] p2_btn_o,
	output logic [1:0] coin_o,
	output logic [1:0] start_o
);

	// Control vectors share the joystick layout
	// 0 right, 1 left, 2 down, 3 up, 4 fire A, 5 fire B, 6 start, 7 coin
	logic [7:0] kb_q;
	logic [7:0] kb_nxt;
	logic [7:0] j_p1;
	logic [7:0] j_p2;
	logic [7:0] c_p1;
	logic [7:0] c_p2;
	logic       rot_en;
	logic [3:0] d_p1;
	logic [3:0] d_p2;

	// Quarter turn of {up, down, left, right}
	function automatic logic [3:0] rot_dir(input logic [3:0] d, input logic cw);
		if (cw)
			return {d[1], d[0], d[2], d[3]}; // Up becomes right
		else
			return {d[0], d[1], d[3], d[2]}; // Up becomes left
	endfunction

	// Key state seen in the same cycle as the strobe
	always_comb begin
		kb_nxt = kb_q;
		if (key_strobe_i) begin
			case (key_code_i)
				`ARC_KEY_RIGHT:  kb_nxt[0] = key_pressed_i;
				`ARC_KEY_LEFT:   kb_nxt[1] = key_pressed_i;
				`ARC_KEY_DOWN:   kb_nxt[2] = key_pressed_i;
				`ARC_KEY_UP:     kb_nxt[3] = key_pressed_i;
				`ARC_KEY_FIRE_A: kb_nxt[4] = key_pressed_i;
				`ARC_KEY_FIRE_B: kb_nxt[5] = key_pressed_i;
				`ARC_KEY_START:  kb_nxt[6] = key_pressed_i;
				`ARC_KEY_COIN:   kb_nxt[7] = key_pressed_i;
				default: ;
			endcase
		end
	end

	assign j_p1 = joyswap_i ? joy1_i : joy0_i;
	assign j_p2 = joyswap_i ? joy0_i : joy1_i;
	assign c_p1 = kb_nxt | j_p1; // Keyboard drives player 1 only
	assign c_p2 = j_p2;

	assign rot_en = rotate_i & orientation_i[0];
	assign d_p1   = rot_en ? rot_dir(c_p1[3:0], orientation_i[1]) : c_p1[3:0];
	assign d_p2   = rot_en ? rot_dir(c_p2[3:0], orientation_i[1]) : c_p2[3:0];

	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			kb_q     <= '0;
			p1_dir_o <= '0;
			p1_btn_o <= '0;
			p2_dir_o <= '0;
			p2_btn_o <= '0;
			coin_o   <= '0;
			start_o  <= '0;
		end else begin
			kb_q     <= kb_nxt;
			p1_dir_o <= d_p1;
			p1_btn_o <= c_p1[5:4];
			p2_dir_o <= oneplayer_i ? d_p1 : d_p2;
			p2_btn_o <= oneplayer_i ? c_p1[5:4] : c_p2[5:4];
			coin_o   <= {c_p2[7], c_p1[7]};
			start_o  <= {c_p2[6], c_p1[6]};
		end
	end

endmodule

//--- src/arc_shell_top.sv
`timescale 1ns/1ps

module arc_shell_top (
	input  logic                 clk_sys,
	input  logic                 rst_n_i,
	// Host download
	input  logic                 ioctl_downl_i,
	input  logic                 ioctl_wr_i,
	input  logic [24:0]          ioctl_addr_i,
	input  logic [7:0]           ioctl_dout_i,
	// Host status and board id
	input  logic [31:0]          status_i,
	input  logic [1:0]           buttons_i,
	input  arc_pkg::hw_variant_t core_mod_i,
	input  logic                 key_strobe_i,
	input  logic                 key_pressed_i,
	input  logic [7:0]           key_code_i,
	input  logic [7:0]           joy0_i,
	input  logic [7:0]           joy1_i,
	output logic                 core_reset_o,
	output logic                 led_o,
	output logic                 port1_req_o,
	output logic                 port2_req_o,
	output arc_pkg::rom_region_t region_o,
	output logic                 prom_wr_o,
	output logic [11:0]          prom_addr_o,
	output logic [7:0]           prom_data_o,
	output logic                 palmode_o,
	output logic [1:0]           rotate_o,
	output logic [1:0]           scanlines_o,
	output logic                 blend_o,
	output logic                 service_o,
	output logic [1:0]           orientation_o,
	output logic                 oneplayer_o,
	output logic [7:0]           dsw1_o,
	output logic [3:0]           p1_dir_o,
	output logic [1:0]           p1_btn_o,
	output logic [3:0]           p2_dir_o,
	output logic [1:0]           p2_btn_o,
	output logic [1:0]           coin_o,
	output logic [1:0]           start_o
);

	logic rst_req;
	logic joyswap;

	assign rst_req = status_i[0] | buttons_i[1]; // OSD reset or user button

	arc_shell_ctrl u_ctrl (
		.clk_sys       (clk_sys),
		.rst_n_i       (rst_n_i),
		.ioctl_downl_i (ioctl_downl_i),
		.rst_req_i     (rst_req),
		.core_reset_o  (core_reset_o),
		.led_o         (led_o),
		.state_o       () // Observed by the checker only
	);

	arc_dl_router u_router (
		.clk_sys       (clk_sys),
		.rst_n_i       (rst_n_i),
		.ioctl_downl_i (ioctl_downl_i),
		.ioctl_wr_i    (ioctl_wr_i),
		.ioctl_addr_i  (ioctl_addr_i),
		.ioctl_dout_i  (ioctl_dout_i),
		.port1_req_o   (port1_req_o),
		.port2_req_o   (port2_req_o),
		.region_o      (region_o),
		.prom_wr_o     (prom_wr_o),
		.prom_addr_o   (prom_addr_o),
		.prom_data_o   (prom_data_o)
	);

	arc_cfg_decode u_cfg (
		.clk_sys       (clk_sys),
		.rst_n_i       (rst_n_i),
		.status_i      (status_i),
		.core_mod_i    (core_mod_i),
		.palmode_o     (palmode_o),
		.rotate_o      (rotate_o),
		.scanlines_o   (scanlines_o),
		.blend_o       (blend_o),
		.service_o     (service_o),
		.joyswap_o     (joyswap),
		.orientation_o (orientation_o),
		.oneplayer_o   (oneplayer_o),
		.dsw1_o        (dsw1_o)
	);

	arc_input_map u_inputs (
		.clk_sys       (clk_sys),
		.rst_n_i       (rst_n_i),
		.key_strobe_i  (key_strobe_i),
		.key_pressed_i (key_pressed_i),
		.key_code_i    (key_code_i),
		.joy0_i        (joy0_i),
		.joy1_i        (joy1_i),
		.rotate_i      (rotate_o[0]),
		.orientation_i (orientation_o),
		.joyswap_i     (joyswap),
		.oneplayer_i   (oneplayer_o),
		.p1_dir_o      (p1_dir_o),
		.p1_btn_o      (p1_btn_o),
		.p2_dir_o      (p2_dir_o),
		.p2_btn_o      (p2_btn_o),
		.coin_o        (coin_o),
		.start_o       (start_o)
	);

endmodule

//--- tb/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
	parameter int PERIOD_NS = 40
) (
	output logic clk_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD_NS / 2) clk_o = ~clk_o;
	end

endmodule

//--- tb/arc_shell_chk.sv
`timescale 1ns/1ps

module arc_shell_chk (
	input logic                  clk_sys,
	input logic                  rst_n_i,
	input arc_pkg::shell_state_t state_i,
	input logic                  core_reset_i,
	input logic                  downl_i,
	input logic                  port1_i,
	input logic                  port2_i,
	input logic                  prom_wr_i,
	input arc_pkg::rom_region_t  region_i
);

	a_reset_outside_run: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		state_i != arc_pkg::ST_RUN |-> core_reset_i)
		else $error("core reset low outside run state");

	// Toggle seen now happened on the previous edge
	a_toggle_in_download: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		(port1_i != $past(port1_i) || port2_i != $past(port2_i)) |-> $past(downl_i))
		else $error("port request toggled outside a download");

	a_prom_region: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		prom_wr_i |-> region_i == arc_pkg::RGN_PROM)
		else $error("PROM write outside the PROM region");

	a_hold_exit: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		state_i == arc_pkg::ST_HOLD |=>
			state_i inside {arc_pkg::ST_HOLD, arc_pkg::ST_RUN, arc_pkg::ST_LOAD})
		else $error("hold state left for boot");

endmodule

// Controller side, router inputs held quiet
bind arc_shell_ctrl arc_shell_chk u_chk (
	.clk_sys      (clk_sys),
	.rst_n_i      (rst_n_i),
	.state_i      (state_o),
	.core_reset_i (core_reset_o),
	.downl_i      (ioctl_downl_i),
	.port1_i      (1'b0),
	.port2_i      (1'b0),
	.prom_wr_i    (1'b0),
	.region_i     (arc_pkg::RGN_PROM)
);

bind arc_dl_router arc_shell_chk u_chk (
	.clk_sys      (clk_sys),
	.rst_n_i      (rst_n_i),
	.state_i      (arc_pkg::ST_RUN), // Run with reset low keeps the FSM checks idle
	.core_reset_i (1'b0),
	.downl_i      (ioctl_downl_i),
	.port1_i      (port1_req_o),
	.port2_i      (port2_req_o),
	.prom_wr_i    (prom_wr_o),
	.region_i     (region_o)
);

//--- tb/arc_shell_tb.sv
`timescale 1ns/1ps

`include "arc_macros.svh"

module arc_shell_tb;

	localparam int MAX_CYCLES = 5000; // Full sequence is a few hundred cycles

	// Region bounds, index matches rgn_order
	localparam logic [24:0] RGN_LO [5] = '{25'h0, 25'(`ARC_SND_BASE), 25'(`ARC_GFX_BASE),
		25'(`ARC_PROM_BASE), 25'(`ARC_ROM_END)};
	localparam logic [24:0] RGN_HI [5] = '{25'(`ARC_SND_BASE), 25'(`ARC_GFX_BASE),
		25'(`ARC_PROM_BASE), 25'(`ARC_ROM_END), 25'(`ARC_ROM_END) + 25'h1000};

	logic                 clk_sys;
	logic                 rst_n;
	logic                 ioctl_downl;
	logic                 ioctl_wr;
	logic [24:0]          ioctl_addr;
	logic [7:0]           ioctl_dout;
	logic [31:0]          status;
	logic [1:0]           buttons;
	arc_pkg::hw_variant_t core_mod;
	logic                 key_strobe;
	logic                 key_pressed;
	logic [7:0]           key_code;
	logic [7:0]           joy0;
	logic [7:0]           joy1;
	logic                 core_reset;
	logic                 led;
	logic                 port1_req;
	logic                 port2_req;
	arc_pkg::rom_region_t region;
	logic                 prom_wr;
	logic [11:0]          prom_addr;
	logic [7:0]           prom_data;
	logic                 palmode;
	logic [1:0]           rotate;
	logic [1:0]           scanlines;
	logic                 blend;
	logic                 service;
	logic [1:0]           orientation;
	logic                 oneplayer;
	logic [7:0]           dsw1;
	logic [3:0]           p1_dir;
	logic [1:0]           p1_btn;
	logic [3:0]           p2_dir;
	logic [1:0]           p2_btn;
	logic [1:0]           coin;
	logic [1:0]           start;
	int                   errors = 0;
	int                   checks = 0;
	int                   cycles;

	tb_clkgen #(.PERIOD_NS(40)) u_clk (.clk_o(clk_sys));

	arc_shell_top dut (
		.clk_sys(clk_sys), .rst_n_i(rst_n),
		.ioctl_downl_i(ioctl_downl), .ioctl_wr_i(ioctl_wr),
		.ioctl_addr_i(ioctl_addr), .ioctl_dout_i(ioctl_dout),
		.status_i(status), .buttons_i(buttons), .core_mod_i(core_mod),
		.key_strobe_i(key_strobe), .key_pressed_i(key_pressed), .key_code_i(key_code),
		.joy0_i(joy0), .joy1_i(joy1),
		.core_reset_o(core_reset), .led_o(led),
		.port1_req_o(port1_req), .port2_req_o(port2_req), .region_o(region),
		.prom_wr_o(prom_wr), .prom_addr_o(prom_addr), .prom_data_o(prom_data),
		.palmode_o(palmode), .rotate_o(rotate), .scanlines_o(scanlines),
		.blend_o(blend), .service_o(service), .orientation_o(orientation),
		.oneplayer_o(oneplayer), .dsw1_o(dsw1),
		.p1_dir_o(p1_dir), .p1_btn_o(p1_btn), .p2_dir_o(p2_dir), .p2_btn_o(p2_btn),
		.coin_o(coin), .start_o(start)
	);

	task automatic check_bit(input string what, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_region(input string what, input arc_pkg::rom_region_t got,
			input arc_pkg::rom_region_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t ns: %s is %s, expected %s", $time, what, got.name(),
				exp.name());
		end
	endtask

	task automatic check_vec(input string what, input logic [11:0] got, input logic [11:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		$display("%s finished with %0d errors", name, errors - errs_before);
	endtask

	task automatic test_reset();
		int e0;
		e0 = errors;
		check_bit("core_reset_o", core_reset, 1'b1);
		check_bit("port1_req_o", port1_req, 1'b0);
		check_bit("port2_req_o", port2_req, 1'b0);
		check_bit("prom_wr_o", prom_wr, 1'b0);
		@(negedge clk_sys);
		check_bit("led_o", led, 1'b1); // Follows the idle download line
		report_test("reset", e0);
	endtask

	task automatic test_download();
		arc_pkg::rom_region_t rgn_order [5];
		arc_pkg::rom_region_t rgn;
		logic [24:0]          addr;
		logic [7:0]           data;
		logic                 p1_prev;
		logic                 p2_prev;
		int                   k;
		int                   e0;
		e0 = errors;
		rgn_order = '{arc_pkg::RGN_CPU, arc_pkg::RGN_SND, arc_pkg::RGN_GFX,
			arc_pkg::RGN_PROM, arc_pkg::RGN_NONE};
		ioctl_downl = 1'b1;
		@(negedge clk_sys);
		for (int i = 0; i < 40; i++) begin
			k       = i % 5;
			rgn     = rgn_order[k];
			addr    = RGN_LO[k] + 25'($urandom % 32'(RGN_HI[k] - RGN_LO[k]));
			data    = 8'($urandom);
			p1_prev = port1_req;
			p2_prev = port2_req;
			ioctl_addr = addr;
			ioctl_dout = data;
			ioctl_wr   = 1'b1;
			@(negedge clk_sys);
			ioctl_wr = 1'b0;
			check_bit("led_o in download", led, 1'b0);
			check_bit("port1_req_o", port1_req, ~p1_prev);
			check_bit("port2_req_o", port2_req, p2_prev ^ (addr >= 25'(`ARC_GFX_BASE)));
			check_region("region_o", region, rgn);
			check_bit("prom_wr_o", prom_wr, rgn == arc_pkg::RGN_PROM);
			if (rgn == arc_pkg::RGN_PROM) begin
				check_vec("prom_addr_o", prom_addr, 12'(addr - 25'(`ARC_PROM_BASE)));
				check_vec("prom_data_o", 12'(prom_data), 12'(data));
			end
			@(negedge clk_sys);
			check_bit("prom_wr_o pulse end", prom_wr, 1'b0);
		end
		report_test("download", e0);
	endtask

	task automatic test_hold();
		int e0;
		e0 = errors;
		ioctl_downl = 1'b0;
		repeat (`ARC_RST_HOLD) begin
			@(negedge clk_sys);
			check_bit("core_reset_o in hold", core_reset, 1'b1);
		end
		@(negedge clk_sys);
		check_bit("core_reset_o after hold", core_reset, 1'b0);
		report_test("hold", e0);
	endtask

	task automatic test_config();
		arc_pkg::hw_variant_t mods [4];
		logic [31:0]          st;
		logic [1:0]           exp_or;
		int                   e0;
		e0 = errors;
		mods = '{arc_pkg::HW_LDRUN, arc_pkg::HW_LDRUN4, arc_pkg::HW_BATTROAD,
			arc_pkg::HW_YOUJYUDN};
		for (int m = 0; m < 4; m++) begin
			for (int s = 0; s < 4; s++) begin
				st = (s == 0) ? 32'h0 : (s == 1) ? 32'hffff_fffe : ($urandom & 32'hffff_fffe);
				core_mod = mods[m];
				status   = st; // Bit 0 stays low, it would reset the game
				@(negedge clk_sys);
				exp_or = 2'b10;
				if (mods[m] == arc_pkg::HW_BATTROAD)
					exp_or = 2'b11;
				if (mods[m] == arc_pkg::HW_YOUJYUDN)
					exp_or = 2'b01;
				check_bit("palmode_o", palmode, st[1]);
				check_vec("rotate_o", 12'(rotate), 12'({exp_or[1], st[2]}));
				check_vec("scanlines_o", 12'(scanlines), 12'(st[4:3]));
				check_bit("blend_o", blend, st[5]);
				check_bit("service_o", service, st[7]);
				check_vec("orientation_o", 12'(orientation), 12'(exp_or));
				check_bit("oneplayer_o", oneplayer, mods[m] != arc_pkg::HW_LDRUN4);
				check_vec("dsw1_o", 12'(dsw1), 12'({4'hf, ~st[11:8]}));
			end
		end
		report_test("config", e0);
	endtask

	task automatic set_cfg(input arc_pkg::hw_variant_t mod, input logic [31:0] st);
		core_mod = mod;
		status   = st;
		@(negedge clk_sys);
	endtask

	task automatic press_key(input logic [7:0] code, input logic pressed);
		key_code    = code;
		key_pressed = pressed;
		key_strobe  = 1'b1;
		@(negedge clk_sys);
		key_strobe = 1'b0;
	endtask

	task automatic set_joy(input logic [7:0] j0, input logic [7:0] j1);
		joy0 = j0;
		joy1 = j1;
		@(negedge clk_sys);
	endtask

	task automatic check_ctrls(input logic [3:0] d1, input logic [1:0] b1, input logic [3:0] d2,
			input logic [1:0] b2);
		check_vec("p1_dir_o", 12'(p1_dir), 12'(d1));
		check_vec("p1_btn_o", 12'(p1_btn), 12'(b1));
		check_vec("p2_dir_o", 12'(p2_dir), 12'(d2));
		check_vec("p2_btn_o", 12'(p2_btn), 12'(b2));
	endtask

	task automatic test_inputs();
		int e0;
		e0 = errors;
		set_cfg(arc_pkg::HW_LDRUN, 32'h0); // One player, player 2 mirrors
		press_key(`ARC_KEY_UP, 1'b1);
		check_ctrls(4'b1000, 2'b00, 4'b1000, 2'b00);
		press_key(`ARC_KEY_FIRE_A, 1'b1);
		check_ctrls(4'b1000, 2'b01, 4'b1000, 2'b01);
		press_key(`ARC_KEY_UP, 1'b0);
		check_ctrls(4'b0000, 2'b01, 4'b0000, 2'b01);
		press_key(`ARC_KEY_FIRE_A, 1'b0);
		press_key(`ARC_KEY_COIN, 1'b1);
		check_vec("coin_o", 12'(coin), 12'h001);
		press_key(`ARC_KEY_COIN, 1'b0);
		press_key(`ARC_KEY_LEFT, 1'b1);
		set_joy(8'h21, 8'h00); // Right and fire B on top of the held key
		check_ctrls(4'b0011, 2'b10, 4'b0011, 2'b10);
		press_key(`ARC_KEY_LEFT, 1'b0);
		set_cfg(arc_pkg::HW_LDRUN4, 32'h0);
		set_joy(8'h02, 8'h54);
		check_ctrls(4'b0010, 2'b00, 4'b0100, 2'b01);
		check_vec("start_o", 12'(start), 12'h002);
		set_cfg(arc_pkg::HW_LDRUN4, 32'h40);
		set_joy(8'h02, 8'h54);
		check_ctrls(4'b0100, 2'b01, 4'b0010, 2'b00);
		check_vec("start_o swapped", 12'(start), 12'h001);
		set_cfg(arc_pkg::HW_BATTROAD, 32'h4); // Clockwise turn
		set_joy(8'h08, 8'h00);
		check_ctrls(4'b0001, 2'b00, 4'b0001, 2'b00);
		set_joy(8'h01, 8'h00);
		check_ctrls(4'b0100, 2'b00, 4'b0100, 2'b00);
		set_cfg(arc_pkg::HW_BATTROAD, 32'h0);
		set_joy(8'h08, 8'h00);
		check_ctrls(4'b1000, 2'b00, 4'b1000, 2'b00);
		set_cfg(arc_pkg::HW_YOUJYUDN, 32'h4); // Counter-clockwise turn
		set_joy(8'h08, 8'h00);
		check_ctrls(4'b0010, 2'b00, 4'b0010, 2'b00);
		set_joy(8'h02, 8'h00);
		check_ctrls(4'b0100, 2'b00, 4'b0100, 2'b00);
		set_cfg(arc_pkg::HW_LDRUN, 32'h0);
		set_joy(8'h00, 8'h00);
		report_test("inputs", e0);
	endtask

	task automatic test_reset_req();
		int e0;
		e0 = errors;
		check_bit("core_reset_o in run", core_reset, 1'b0);
		for (int src = 0; src < 2; src++) begin
			if (src == 0)
				status[0] = 1'b1;
			else
				buttons[1] = 1'b1;
			@(negedge clk_sys);
			check_bit("core_reset_o on request", core_reset, 1'b1);
			status[0]  = 1'b0;
			buttons[1] = 1'b0;
			repeat (`ARC_RST_HOLD - 1) begin
				@(negedge clk_sys);
				check_bit("core_reset_o after request", core_reset, 1'b1);
			end
			@(negedge clk_sys);
			check_bit("core_reset_o release", core_reset, 1'b0);
		end
		report_test("reset request", e0);
	endtask

	initial begin
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge clk_sys);
			cycles++;
		end
		$display("Timeout: tests still running after %0d cycles", MAX_CYCLES);
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		void'($urandom(32'hc8db_dd7e));
		rst_n       = 1'b0;
		ioctl_downl = 1'b0;
		ioctl_wr    = 1'b0;
		ioctl_addr  = '0;
		ioctl_dout  = '0;
		status      = '0;
		buttons     = '0;
		core_mod    = arc_pkg::HW_LDRUN;
		key_strobe  = 1'b0;
		key_pressed = 1'b0;
		key_code    = '0;
		joy0        = '0;
		joy1        = '0;
		repeat (2) @(negedge clk_sys);
		rst_n = 1'b1;
		test_reset();
		test_download();
		test_hold();
		test_config();
		test_inputs();
		test_reset_req();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

//--- list.f
+incdir+src
src/arc_pkg.sv
src/arc_shell_ctrl.sv
src/arc_dl_router.sv
src/arc_cfg_decode.sv
src/arc_input_map.sv
src/arc_shell_top.sv
tb/tb_clkgen.sv
tb/arc_shell_chk.sv
tb/arc_shell_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the arcade shell testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -f list.f \
	--top-module arc_shell_tb -o arc_shell_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/arc_shell_sim)
rc=$?
printf '%s\n' "$out"
if [ $rc -ne 0 ]; then
	echo "Simulation exited with status $rc"
	exit 1
fi

if printf '%s\n' "$out" | grep -q "^Result: PASSED$"; then
	exit 0
fi
exit 1
